// File: sources.f
src/mac_cfg_pkg.sv
src/mac_mem_pkg.sv
src/clk_phase_gen.sv
src/sys_config.sv
src/rom_download.sv
src/disk_presence.sv
src/mem_port_mux.sv
src/activity_led.sv
src/mac_glue_top.sv
tests/tb_mac_glue.sv

// File: src/activity_led.sv
module activity_led #(
	parameter int ACT_HOLD = 1000000
) (
	input  logic       clk_sys,
	input  logic       n_reset,
	input  logic [1:0] disk_act_in,
	input  logic [1:0] disk_motor,
	input  logic       ioctl_download,
	output logic       led_user
);

	localparam int HOLD_W = $clog2(ACT_HOLD + 1);

	logic [HOLD_W-1:0] hold_cnt;
	logic              disk_act;

	// flag stays up ACT_HOLD cycles after the last activity pulse
	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			hold_cnt <= '0;
			disk_act <= 1'b0;
		end else if (|disk_act_in) begin
			// retrigger, this cycle counts as the first of the hold
			hold_cnt <= HOLD_W'(ACT_HOLD - 1);
			disk_act <= 1'b1;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
			disk_act <= 1'b1;
		end else begin
			disk_act <= 1'b0;
		end
	end

	// steady during a download
	// with a motor running the led blinks off on activity
	assign led_user = ioctl_download || (disk_act ^ (|disk_motor));

endmodule

// File: src/clk_phase_gen.sv
module clk_phase_gen (
	input  logic clk_sys,
	input  logic n_reset,
	output logic cep,
	output logic cen,
	output logic cel,
	output logic cepix
);

	// eight stages per cpu bus cycle
	logic [2:0] stage;

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			stage <= 3'd0;
		end else begin
			stage <= stage + 3'd1;
		end
	end

	// positive cpu phase
	assign cep = (stage == 3'd0);
	// negative cpu phase, half a cycle later
	assign cen = (stage == 3'd4);
	// data latch at the end of the bus cycle
	assign cel = (stage == 3'd7);
	// pixel enable, every fourth clock
	assign cepix = (stage[1:0] == 2'b00);

endmodule

// File: src/disk_presence.sv
module disk_presence #(
	parameter logic [7:0] DRIVE_IDX = 8'd1
) (
	input  logic        clk_sys,
	input  logic        n_reset,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic [20:0] end_addr,
	input  logic        eject,
	output logic        inserted,
	output logic        double_sided
);
	import mac_cfg_pkg::*;
	import mac_mem_pkg::*;

	// end_addr carries the image base, so the sizes are compared with it added
	localparam logic [20:0] IMG_BASE = (DRIVE_IDX == DL_IDX_DSK0) ? DSK0_BASE : DSK1_BASE;
	localparam logic [20:0] DS_END   = IMG_BASE + 21'(DSK_DS_WORDS);
	localparam logic [20:0] SS_END   = IMG_BASE + 21'(DSK_SS_WORDS);

	logic old_down;
	logic single_sided;

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			old_down     <= 1'b0;
			double_sided <= 1'b0;
			single_sided <= 1'b0;
		end else begin
			old_down <= ioctl_download;
			// end of a download for this drive, size tells the format
			if (old_down && !ioctl_download && ioctl_index == DRIVE_IDX) begin
				double_sided <= (end_addr == DS_END);
				single_sided <= (end_addr == SS_END);
			end
			// set by the os on eject
			if (eject) begin
				double_sided <= 1'b0;
				single_sided <= 1'b0;
			end
		end
	end

	// unknown sizes leave the drive empty
	assign inserted = double_sided || single_sided;

endmodule

// File: src/mac_cfg_pkg.sv
package mac_cfg_pkg;

	// ============================================================
	// host status word
	// ============================================================

	// status word as delivered by the host menu
	typedef logic [31:0] status_w_t;

	// bit positions inside the status word
	localparam int ST_HOST_RESET = 0;
	// turbo request, applied only after the boot delay
	localparam int ST_TURBO = 5;
	localparam int ST_RESET = 6;
	// low end of the two bit memory size field
	localparam int ST_MEM_LO = 9;

	// ============================================================
	// memory configuration
	// ============================================================

	// 0 = 128 KB, 1 = 512 KB, 2 = 1 MB, 3 = 4 MB
	typedef logic [1:0] ram_size_t;

	// ============================================================
	// download indices and disk images
	// ============================================================

	// index sent by the host with every download
	localparam logic [7:0] DL_IDX_ROM = 8'd0;
	// primary floppy
	localparam logic [7:0] DL_IDX_DSK0 = 8'd1;
	// secondary floppy
	localparam logic [7:0] DL_IDX_DSK1 = 8'd2;

	// good image sizes counted in 16 bit words
	// 819200 bytes, two sides
	localparam int DSK_DS_WORDS = 409600;
	// 409600 bytes, one side
	localparam int DSK_SS_WORDS = 204800;

endpackage

// File: src/mac_glue_top.sv
module mac_glue_top #(
	parameter int RST_CNT_W       = 16,
	parameter int TURBO_ACK_DELAY = 20,
	parameter int ACT_HOLD        = 1000000
) (
	input  logic                    clk_sys,
	input  logic                    n_reset,

	// host and reset sources
	input  mac_cfg_pkg::status_w_t  status,
	input  logic                    button,
	input  logic                    cpu_reset_out_n,
	input  logic                    pll_locked,

	// ioctl download stream
	input  logic                    ioctl_download,
	input  logic [7:0]              ioctl_index,
	input  logic                    ioctl_write,
	input  logic [24:0]             ioctl_addr,
	input  logic [7:0]              ioctl_data,
	output logic                    ioctl_wait,

	// slot grant and cpu memory cycle from the address controller
	input  logic                    dio_bus_ctl,
	input  mac_mem_pkg::cpu_mem_req_t cpu_req,

	// floppy and scsi status
	input  logic [1:0]              dsk_ack,
	input  logic                    sd_ack,
	input  logic [1:0]              disk_motor,
	input  logic [1:0]              disk_eject,
	input  logic [1:0]              disk_act_in,

	input  logic [15:0]             sdram_out,

	output logic                    cep,
	output logic                    cen,
	output logic                    cel,
	output logic                    cepix,
	output logic                    sys_run,
	output mac_cfg_pkg::ram_size_t  ram_size,
	output logic                    real_turbo,
	output mac_mem_pkg::sdram_req_t sdram_req,
	output logic [15:0]             mem_data_in,
	output logic                    screen_wr,
	output logic [1:0]              dsk_inserted,
	output logic [1:0]              dsk_double,
	output logic                    led_user
);
	import mac_cfg_pkg::*;
	import mac_mem_pkg::*;

	// paired download word toward the sdram mux
	dl_req_t dl_req;

	clk_phase_gen u_clk_phase_gen (
		.clk_sys (clk_sys),
		.n_reset (n_reset),
		.cep     (cep),
		.cen     (cen),
		.cel     (cel),
		.cepix   (cepix)
	);

	sys_config #(
		.RST_CNT_W       (RST_CNT_W),
		.TURBO_ACK_DELAY (TURBO_ACK_DELAY)
	) u_sys_config (
		.clk_sys         (clk_sys),
		.n_reset         (n_reset),
		.pll_locked      (pll_locked),
		.status          (status),
		.button          (button),
		.cpu_reset_out_n (cpu_reset_out_n),
		.cen             (cen),
		.sd_ack          (sd_ack),
		.disk_motor      (disk_motor),
		.dio_bus_ctl     (dio_bus_ctl),
		.sys_run         (sys_run),
		.ram_size        (ram_size),
		.real_turbo      (real_turbo)
	);

	rom_download u_rom_download (
		.clk_sys        (clk_sys),
		.n_reset        (n_reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_write    (ioctl_write),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.dio_bus_ctl    (dio_bus_ctl),
		.ioctl_wait     (ioctl_wait),
		.dl_req         (dl_req)
	);

	// primary drive
	disk_presence #(
		.DRIVE_IDX (DL_IDX_DSK0)
	) u_disk_presence_0 (
		.clk_sys        (clk_sys),
		.n_reset        (n_reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.end_addr       (dl_req.addr),
		.eject          (disk_eject[0]),
		.inserted       (dsk_inserted[0]),
		.double_sided   (dsk_double[0])
	);

	// secondary drive
	disk_presence #(
		.DRIVE_IDX (DL_IDX_DSK1)
	) u_disk_presence_1 (
		.clk_sys        (clk_sys),
		.n_reset        (n_reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.end_addr       (dl_req.addr),
		.eject          (disk_eject[1]),
		.inserted       (dsk_inserted[1]),
		.double_sided   (dsk_double[1])
	);

	mem_port_mux u_mem_port_mux (
		.cpu_req     (cpu_req),
		.dl_req      (dl_req),
		.ram_size    (ram_size),
		.dsk_ack     (dsk_ack),
		.sdram_out   (sdram_out),
		.sdram_req   (sdram_req),
		.mem_data_in (mem_data_in),
		.screen_wr   (screen_wr)
	);

	activity_led #(
		.ACT_HOLD (ACT_HOLD)
	) u_activity_led (
		.clk_sys        (clk_sys),
		.n_reset        (n_reset),
		.disk_act_in    (disk_act_in),
		.disk_motor     (disk_motor),
		.ioctl_download (ioctl_download),
		.led_user       (led_user)
	);

endmodule

// File: src/mac_mem_pkg.sv
package mac_mem_pkg;

	// ============================================================
	// requests toward the sdram
	// ============================================================

	// cpu side memory cycle from the address controller
	typedef struct packed {
		logic [21:0] mem_addr;
		logic        uds_n;
		logic        lds_n;
		logic        rom_oe_n;
		logic        ram_oe_n;
		logic        ram_we_n;
		logic [15:0] data;
	} cpu_mem_req_t;

	// one paired word from the download path
	typedef struct packed {
		// download running and the slot belongs to it
		logic        active;
		logic        write;
		// word address with the image base already added
		logic [20:0] addr;
		logic [15:0] data;
	} dl_req_t;

	// download layout of the sdram word address
	typedef struct packed {
		logic [3:0]  region;
		logic [20:0] addr;
	} sdram_dl_addr_t;

	// cpu layout, rom and ram share the low 21 bits
	typedef struct packed {
		logic [2:0]  zero;
		logic        rom_sel;
		logic [20:0] addr;
	} sdram_cpu_addr_t;

	// one 25 bit word, two ways to read it
	typedef union packed {
		sdram_dl_addr_t  dl;
		sdram_cpu_addr_t cpu;
	} sdram_addr_u;

	typedef struct packed {
		sdram_addr_u addr;
		logic [15:0] din;
		// byte lanes, upper then lower
		logic [1:0]  ds;
		logic        we;
		logic        oe;
	} sdram_req_t;

	// ============================================================
	// download memory map
	// ============================================================

	// disk images sit right after the os rom
	localparam logic [20:0] DSK0_BASE = 21'h080000;
	localparam logic [20:0] DSK1_BASE = 21'h100000;

	// region tag used for every download write
	localparam logic [3:0] DL_REGION = 4'b0001;

endpackage

// File: src/mem_port_mux.sv
module mem_port_mux (
	input  mac_mem_pkg::cpu_mem_req_t cpu_req,
	input  mac_mem_pkg::dl_req_t      dl_req,
	input  mac_cfg_pkg::ram_size_t    ram_size,
	input  logic [1:0]                dsk_ack,
	input  logic [15:0]               sdram_out,
	output mac_mem_pkg::sdram_req_t   sdram_req,
	output logic [15:0]               mem_data_in,
	output logic                      screen_wr
);
	import mac_mem_pkg::*;

	logic [7:0] dsk_byte;
	logic       screen_hit;

	// ============================================================
	// sdram request
	// ============================================================

	always_comb begin
		if (dl_req.active) begin
			// download slot, whole words into the upper region
			sdram_req.addr.dl.region = DL_REGION;
			sdram_req.addr.dl.addr   = dl_req.addr;
			sdram_req.din            = dl_req.data;
			sdram_req.ds             = 2'b11;
			sdram_req.we             = dl_req.write;
			sdram_req.oe             = 1'b0;
		end else begin
			// cpu maps straight into the 68k space, rom one bit above ram
			sdram_req.addr.cpu.zero    = 3'b000;
			sdram_req.addr.cpu.rom_sel = !cpu_req.rom_oe_n;
			sdram_req.addr.cpu.addr    = cpu_req.mem_addr[21:1];
			sdram_req.din              = cpu_req.data;
			sdram_req.ds               = {!cpu_req.uds_n, !cpu_req.lds_n};
			sdram_req.we               = !cpu_req.ram_we_n;
			sdram_req.oe               = !cpu_req.ram_oe_n || !cpu_req.rom_oe_n;
		end
	end

	// ============================================================
	// read data
	// ============================================================

	// disk image reads are byte wide, odd address takes the low byte
	assign dsk_byte = cpu_req.mem_addr[0] ? sdram_out[7:0] : sdram_out[15:8];

	always_comb begin
		if (dl_req.active) begin
			mem_data_in = 16'hffff;
		end else if (|dsk_ack) begin
			mem_data_in = {dsk_byte, dsk_byte};
		end else begin
			mem_data_in = sdram_out;
		end
	end

	// ============================================================
	// screen write decode
	// ============================================================

	// frame buffer sits near the top of ram, so the top bits are all ones
	always_comb begin
		case (ram_size)
			2'd0:    screen_hit = &cpu_req.mem_addr[16:15];
			2'd1:    screen_hit = &cpu_req.mem_addr[18:15];
			2'd2:    screen_hit = &cpu_req.mem_addr[19:15];
			default: screen_hit = &cpu_req.mem_addr[21:15];
		endcase
		screen_wr = !cpu_req.ram_we_n && screen_hit;
	end

endmodule

// File: src/rom_download.sv
module rom_download (
	input  logic                 clk_sys,
	input  logic                 n_reset,
	input  logic                 ioctl_download,
	input  logic [7:0]           ioctl_index,
	input  logic                 ioctl_write,
	input  logic [24:0]          ioctl_addr,
	input  logic [7:0]           ioctl_data,
	input  logic                 dio_bus_ctl,
	output logic                 ioctl_wait,
	output mac_mem_pkg::dl_req_t dl_req
);
	import mac_cfg_pkg::*;
	import mac_mem_pkg::*;

	logic [7:0]  even_byte;
	logic [15:0] word_data;
	logic [20:0] word_off;
	logic [20:0] word_addr;
	logic        dio_write;
	logic        old_cyc;

	// ============================================================
	// byte pairing
	// ============================================================

	// even byte goes to the high half, 68k byte order
	always_ff @(posedge clk_sys) begin
		if (ioctl_write) begin
			if (!ioctl_addr[0]) begin
				even_byte <= ioctl_data;
			end else begin
				word_data <= {even_byte, ioctl_data};
			end
		end
	end

	// ============================================================
	// address map
	// ============================================================

	// byte address to word address
	// host keeps the address still while ioctl_wait is high
	assign word_off = ioctl_addr[21:1];

	always_comb begin
		case (ioctl_index)
			DL_IDX_ROM:  word_addr = word_off;
			DL_IDX_DSK0: word_addr = DSK0_BASE + word_off;
			default:     word_addr = DSK1_BASE + word_off;
		endcase
	end

	// ============================================================
	// write and wait handshake
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			ioctl_wait <= 1'b0;
			dio_write  <= 1'b0;
			old_cyc    <= 1'b0;
		end else begin
			old_cyc <= dio_bus_ctl;
			// outside the slot, arm the write for the next one
			if (!dio_bus_ctl) begin
				dio_write <= ioctl_wait;
			end
			// slot just ended with a write, release the host
			if (old_cyc && !dio_bus_ctl && dio_write) begin
				ioctl_wait <= 1'b0;
				dio_write  <= 1'b0;
			end
			// odd byte completes a word
			if (ioctl_write && ioctl_addr[0]) begin
				ioctl_wait <= 1'b1;
			end
		end
	end

	always_comb begin
		dl_req.active = ioctl_download && dio_bus_ctl;
		dl_req.write  = dio_write;
		dl_req.addr   = word_addr;
		dl_req.data   = word_data;
	end

endmodule

// File: src/sys_config.sv
module sys_config #(
	parameter int RST_CNT_W       = 16,
	parameter int TURBO_ACK_DELAY = 20
) (
	input  logic                   clk_sys,
	input  logic                   n_reset,
	input  logic                   pll_locked,
	input  mac_cfg_pkg::status_w_t status,
	input  logic                   button,
	input  logic                   cpu_reset_out_n,
	input  logic                   cen,
	input  logic                   sd_ack,
	input  logic [1:0]             disk_motor,
	input  logic                   dio_bus_ctl,
	output logic                   sys_run,
	output mac_cfg_pkg::ram_size_t ram_size,
	output logic                   real_turbo
);
	import mac_cfg_pkg::*;

	localparam int ACK_W = $clog2(TURBO_ACK_DELAY + 1);

	logic                 rst_any;
	logic [RST_CNT_W-1:0] rst_cnt;
	logic                 old_ack;
	logic [ACK_W-1:0]     ack_cnt;

	// ============================================================
	// reset sequencer
	// ============================================================

	// any of these restarts the whole machine
	assign rst_any = !n_reset || !pll_locked || status[ST_HOST_RESET] ||
		status[ST_RESET] || button || !cpu_reset_out_n;

	always_ff @(posedge clk_sys) begin
		if (rst_any) begin
			rst_cnt <= '1;
			sys_run <= 1'b0;
		end else if (rst_cnt != '0) begin
			// count on the cpu phase only
			if (cen) begin
				rst_cnt <= rst_cnt - 1'b1;
			end
		end else begin
			sys_run <= 1'b1;
		end
	end

	// memory size may only change while the machine is held
	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			ram_size <= 2'd3;
		end else if (rst_cnt != '0) begin
			ram_size <= status[ST_MEM_LO +: 2] + 2'd1;
		end
	end

	// ============================================================
	// delayed turbo
	// ============================================================

	// scsi boot fails at turbo speed, so wait for some scsi acks first
	always_ff @(posedge clk_sys) begin
		if (!n_reset || !sys_run) begin
			old_ack    <= 1'b0;
			ack_cnt    <= ACK_W'(TURBO_ACK_DELAY);
			real_turbo <= 1'b0;
		end else begin
			old_ack <= sd_ack;
			// floppy access means no scsi boot, drop the delay
			if (|disk_motor) begin
				ack_cnt <= '0;
			end else if (old_ack && !sd_ack && ack_cnt != '0) begin
				ack_cnt <= ack_cnt - 1'b1;
			end
			// speed only changes in a download slot
			if (ack_cnt == '0 && dio_bus_ctl) begin
				real_turbo <= status[ST_TURBO];
			end
		end
	end

endmodule

// File: tests/tb_mac_glue.sv
module tb_mac_glue;
	import mac_cfg_pkg::*;
	import mac_mem_pkg::*;

	// cycles allowed for any single wait
	localparam int TIMEOUT = 400;
	// activity hold used for the dut
	localparam int ACT_HOLD = 16;

	logic                  clk_sys;
	logic                  n_reset;
	status_w_t             status;
	logic                  button;
	logic                  cpu_reset_out_n;
	logic                  pll_locked;
	logic                  ioctl_download;
	logic [7:0]            ioctl_index;
	logic                  ioctl_write;
	logic [24:0]           ioctl_addr;
	logic [7:0]            ioctl_data;
	logic                  ioctl_wait;
	logic                  dio_bus_ctl;
	cpu_mem_req_t          cpu_req;
	logic [1:0]            dsk_ack;
	logic                  sd_ack;
	logic [1:0]            disk_motor;
	logic [1:0]            disk_eject;
	logic [1:0]            disk_act_in;
	logic [15:0]           sdram_out;
	logic                  cep;
	logic                  cen;
	logic                  cel;
	logic                  cepix;
	logic                  sys_run;
	ram_size_t             ram_size;
	logic                  real_turbo;
	sdram_req_t            sdram_req;
	logic [15:0]           mem_data_in;
	logic                  screen_wr;
	logic [1:0]            dsk_inserted;
	logic [1:0]            dsk_double;
	logic                  led_user;

	int errors;
	int timeouts;

	mac_glue_top #(
		.RST_CNT_W       (4),
		.TURBO_ACK_DELAY (3),
		.ACT_HOLD        (ACT_HOLD)
	) dut0 (
		.clk_sys         (clk_sys),
		.n_reset         (n_reset),
		.status          (status),
		.button          (button),
		.cpu_reset_out_n (cpu_reset_out_n),
		.pll_locked      (pll_locked),
		.ioctl_download  (ioctl_download),
		.ioctl_index     (ioctl_index),
		.ioctl_write     (ioctl_write),
		.ioctl_addr      (ioctl_addr),
		.ioctl_data      (ioctl_data),
		.ioctl_wait      (ioctl_wait),
		.dio_bus_ctl     (dio_bus_ctl),
		.cpu_req         (cpu_req),
		.dsk_ack         (dsk_ack),
		.sd_ack          (sd_ack),
		.disk_motor      (disk_motor),
		.disk_eject      (disk_eject),
		.disk_act_in     (disk_act_in),
		.sdram_out       (sdram_out),
		.cep             (cep),
		.cen             (cen),
		.cel             (cel),
		.cepix           (cepix),
		.sys_run         (sys_run),
		.ram_size        (ram_size),
		.real_turbo      (real_turbo),
		.sdram_req       (sdram_req),
		.mem_data_in     (mem_data_in),
		.screen_wr       (screen_wr),
		.dsk_inserted    (dsk_inserted),
		.dsk_double      (dsk_double),
		.led_user        (led_user)
	);

	always #4 clk_sys = !clk_sys;

	// ============================================================
	// reporting
	// ============================================================

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error %s: got %0h, expected %0h", name, got, exp);
		errors++;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		timeouts++;
	endtask

	// ============================================================
	// clock enables and reset
	// ============================================================

	// every task starts and ends on a falling edge
	task automatic check_enables();
		int i;
		int k;
		i = 0;
		while (cep !== 1'b1 && i < 8) begin
			@(negedge clk_sys);
			i++;
		end
		if (cep !== 1'b1) begin
			report_timeout("cep never went high after reset");
		end else begin
			// two full cep periods with cen half way and cepix every fourth
			for (k = 0; k < 16; k++) begin
				if (cep !== (k % 8 == 0)) report_mismatch("cep", cep, k % 8 == 0);
				if (cen !== (k % 8 == 4)) report_mismatch("cen", cen, k % 8 == 4);
				if (cel !== (k % 8 == 7)) report_mismatch("cel", cel, k % 8 == 7);
				if (cepix !== (k % 4 == 0)) report_mismatch("cepix", cepix, k % 4 == 0);
				@(negedge clk_sys);
			end
		end
	endtask

	task automatic wait_run();
		int i;
		i = 0;
		while (sys_run !== 1'b1 && i < TIMEOUT) begin
			@(negedge clk_sys);
			i++;
		end
		if (sys_run !== 1'b1) report_timeout("sys_run did not rise");
	endtask

	// user reset with a new memory field gives a size of field plus one
	task automatic apply_mem_size(input logic [1:0] field);
		logic [1:0] exp_size;
		exp_size = field + 2'd1;
		status[ST_MEM_LO +: 2] = field;
		button = 1'b1;
		@(negedge clk_sys);
		button = 1'b0;
		if (sys_run !== 1'b0) report_mismatch("sys_run", sys_run, 0);
		wait_run();
		if (ram_size !== exp_size) report_mismatch("ram_size", ram_size, exp_size);
	endtask

	// ============================================================
	// download path
	// ============================================================

	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_write = 1'b1;
		@(negedge clk_sys);
		ioctl_write = 1'b0;
	endtask

	task automatic send_word(input logic [7:0] idx, input logic [20:0] word,
		input logic [7:0] even, input logic [7:0] odd);
		logic [20:0] exp_addr;
		int          i;
		int          found;
		// disk images sit above the rom
		if (idx == 8'd1) exp_addr = 21'h080000 + word;
		else if (idx == 8'd2) exp_addr = 21'h100000 + word;
		else exp_addr = word;
		send_byte({3'b000, word, 1'b0}, even);
		send_byte({3'b000, word, 1'b1}, odd);
		// odd byte holds the host off
		if (ioctl_wait !== 1'b1) report_mismatch("ioctl_wait", ioctl_wait, 1);
		// random gap before the slot is granted
		repeat (1 + $urandom % 4) @(negedge clk_sys);
		dio_bus_ctl = 1'b1;
		found = 0;
		i = 0;
		while (!found && i < TIMEOUT) begin
			@(negedge clk_sys);
			if (sdram_req.we === 1'b1) found = 1;
			i++;
		end
		if (!found) begin
			report_timeout("no sdram write for a download word");
		end else begin
			if (sdram_req.addr.dl.region !== 4'b0001)
				report_mismatch("sdram_req.addr.dl.region", sdram_req.addr.dl.region, 1);
			if (sdram_req.addr.dl.addr !== exp_addr)
				report_mismatch("sdram_req.addr.dl.addr", sdram_req.addr.dl.addr, exp_addr);
			if (sdram_req.din !== {even, odd})
				report_mismatch("sdram_req.din", sdram_req.din, {even, odd});
			if (sdram_req.ds !== 2'b11) report_mismatch("sdram_req.ds", sdram_req.ds, 3);
			if (sdram_req.oe !== 1'b0) report_mismatch("sdram_req.oe", sdram_req.oe, 0);
		end
		dio_bus_ctl = 1'b0;
		// end of slot releases the host
		i = 0;
		while (ioctl_wait !== 1'b0 && i < TIMEOUT) begin
			@(negedge clk_sys);
			i++;
		end
		if (ioctl_wait !== 1'b0) report_timeout("ioctl_wait stayed high");
	endtask

	// two words and then the address moves past the image end
	task automatic download_image(input logic [7:0] idx, input logic [20:0] start,
		input logic [31:0] bytes, input logic [1:0] ins, input logic [1:0] dbl);
		logic [20:0] end_word;
		end_word = start + 21'd2;
		ioctl_index = idx;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		// led stays lit for the whole download
		if (led_user !== 1'b1) report_mismatch("led_user", led_user, 1);
		send_word(idx, start, bytes[31:24], bytes[23:16]);
		send_word(idx, start + 21'd1, bytes[15:8], bytes[7:0]);
		ioctl_addr = {3'b000, end_word, 1'b0};
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		@(negedge clk_sys);
		if (dsk_inserted !== ins) report_mismatch("dsk_inserted", dsk_inserted, ins);
		if (dsk_double !== dbl) report_mismatch("dsk_double", dsk_double, dbl);
	endtask

	task automatic eject_drive(input logic [1:0] mask, input logic [1:0] ins,
		input logic [1:0] dbl);
		disk_eject = mask;
		@(negedge clk_sys);
		disk_eject = 2'b00;
		@(negedge clk_sys);
		if (dsk_inserted !== ins) report_mismatch("dsk_inserted", dsk_inserted, ins);
		if (dsk_double !== dbl) report_mismatch("dsk_double", dsk_double, dbl);
	endtask

	// ============================================================
	// cpu side and read data
	// ============================================================

	// ctl holds uds_n, lds_n, rom_oe_n, ram_oe_n, ram_we_n from the top
	task automatic cpu_access(input logic [21:0] addr, input logic [4:0] ctl,
		input logic [15:0] data, input logic [15:0] sdout, input logic [1:0] ack,
		input logic [15:0] exp_data, input logic exp_scr);
		cpu_req.mem_addr = addr;
		{cpu_req.uds_n, cpu_req.lds_n, cpu_req.rom_oe_n, cpu_req.ram_oe_n,
			cpu_req.ram_we_n} = ctl;
		cpu_req.data = data;
		sdram_out = sdout;
		dsk_ack = ack;
		@(negedge clk_sys);
		if (mem_data_in !== exp_data) report_mismatch("mem_data_in", mem_data_in, exp_data);
		if (screen_wr !== exp_scr) report_mismatch("screen_wr", screen_wr, exp_scr);
		if (sdram_req.addr.cpu.zero !== 3'b000)
			report_mismatch("sdram_req.addr.cpu.zero", sdram_req.addr.cpu.zero, 0);
		if (sdram_req.addr.cpu.rom_sel !== !ctl[2])
			report_mismatch("sdram_req.addr.cpu.rom_sel", sdram_req.addr.cpu.rom_sel, !ctl[2]);
		if (sdram_req.addr.cpu.addr !== addr[21:1])
			report_mismatch("sdram_req.addr.cpu.addr", sdram_req.addr.cpu.addr, addr[21:1]);
		if (sdram_req.we !== !ctl[0]) report_mismatch("sdram_req.we", sdram_req.we, !ctl[0]);
		if (sdram_req.din !== data) report_mismatch("sdram_req.din", sdram_req.din, data);
		// active high byte lanes from the active low strobes
		if (sdram_req.ds !== ~ctl[4:3])
			report_mismatch("sdram_req.ds", sdram_req.ds, ~ctl[4:3]);
		// rom or ram output enable
		if (sdram_req.oe !== (!ctl[2] || !ctl[1]))
			report_mismatch("sdram_req.oe", sdram_req.oe, !ctl[2] || !ctl[1]);
		// back to an idle bus
		{cpu_req.uds_n, cpu_req.lds_n, cpu_req.rom_oe_n, cpu_req.ram_oe_n,
			cpu_req.ram_we_n} = 5'b11111;
		dsk_ack = 2'b00;
	endtask

	// ============================================================
	// turbo delay
	// ============================================================

	task automatic turbo_sequence(input int acks);
		int i;
		int k;
		status[ST_TURBO] = 1'b1;
		button = 1'b1;
		@(negedge clk_sys);
		button = 1'b0;
		wait_run();
		for (k = 0; k < acks; k++) begin
			// a grant alone must not switch speed yet
			dio_bus_ctl = 1'b1;
			@(negedge clk_sys);
			@(negedge clk_sys);
			dio_bus_ctl = 1'b0;
			if (real_turbo !== 1'b0) report_mismatch("real_turbo", real_turbo, 0);
			sd_ack = 1'b1;
			@(negedge clk_sys);
			sd_ack = 1'b0;
			@(negedge clk_sys);
		end
		if (real_turbo !== 1'b0) report_mismatch("real_turbo", real_turbo, 0);
		dio_bus_ctl = 1'b1;
		i = 0;
		while (real_turbo !== 1'b1 && i < TIMEOUT) begin
			@(negedge clk_sys);
			i++;
		end
		dio_bus_ctl = 1'b0;
		if (real_turbo !== 1'b1) report_timeout("real_turbo did not rise");
	endtask

	// ============================================================
	// activity led
	// ============================================================

	// hold time of the activity flag and its inversion by a running motor
	task automatic check_led();
		int k;
		disk_motor = 2'b00;
		disk_act_in = 2'b01;
		@(negedge clk_sys);
		disk_act_in = 2'b00;
		if (led_user !== 1'b1) report_mismatch("led_user", led_user, 1);
		// flag stays up ACT_HOLD cycles after the pulse
		for (k = 1; k < ACT_HOLD; k++) begin
			@(negedge clk_sys);
			if (led_user !== 1'b1) report_mismatch("led_user", led_user, 1);
		end
		@(negedge clk_sys);
		if (led_user !== 1'b0) report_mismatch("led_user", led_user, 0);
		// motor on with no activity lights the led
		disk_motor = 2'b10;
		@(negedge clk_sys);
		if (led_user !== 1'b1) report_mismatch("led_user", led_user, 1);
		// activity with the motor running turns it off
		disk_act_in = 2'b10;
		@(negedge clk_sys);
		disk_act_in = 2'b00;
		if (led_user !== 1'b0) report_mismatch("led_user", led_user, 0);
		disk_motor = 2'b00;
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial begin
		int             seed;
		int             fd;
		int             code;
		int             done;
		logic [63:0]    cmd;
		logic [1023:0]  rest;
		logic [31:0]    f [0:7];
		errors = 0;
		timeouts = 0;
		seed = $urandom(32'h0200475d);
		clk_sys = 1'b0;
		n_reset = 1'b0;
		status = '0;
		button = 1'b0;
		cpu_reset_out_n = 1'b1;
		pll_locked = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_write = 1'b0;
		ioctl_addr = '0;
		ioctl_data = 8'd0;
		dio_bus_ctl = 1'b0;
		cpu_req = '0;
		{cpu_req.uds_n, cpu_req.lds_n, cpu_req.rom_oe_n, cpu_req.ram_oe_n,
			cpu_req.ram_we_n} = 5'b11111;
		dsk_ack = 2'b00;
		sd_ack = 1'b0;
		disk_motor = 2'b00;
		disk_eject = 2'b00;
		disk_act_in = 2'b00;
		sdram_out = 16'd0;
		repeat (3) @(negedge clk_sys);
		n_reset = 1'b1;
		check_enables();
		if (sys_run !== 1'b0) report_mismatch("sys_run", sys_run, 0);
		wait_run();
		fd = $fopen("tests/tb_mac_glue_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the input file");
			errors++;
		end else begin
			done = 0;
			while (!done) begin
				code = $fscanf(fd, "%s", cmd);
				if (code != 1) begin
					done = 1;
				end else if (cmd == "#") begin
					code = $fgets(rest, fd);
				end else if (cmd == "mem") begin
					code = $fscanf(fd, "%h", f[0]);
					apply_mem_size(f[0][1:0]);
				end else if (cmd == "dl") begin
					code = $fscanf(fd, "%h %h %h %h %h %h %h %h", f[0], f[1], f[2],
						f[3], f[4], f[5], f[6], f[7]);
					download_image(f[0][7:0], f[1][20:0],
						{f[2][7:0], f[3][7:0], f[4][7:0], f[5][7:0]}, f[6][1:0], f[7][1:0]);
				end else if (cmd == "ej") begin
					code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
					eject_drive(f[0][1:0], f[1][1:0], f[2][1:0]);
				end else if (cmd == "cpu") begin
					code = $fscanf(fd, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
						f[4], f[5], f[6]);
					cpu_access(f[0][21:0], f[1][4:0], f[2][15:0], f[3][15:0], f[4][1:0],
						f[5][15:0], f[6][0]);
				end else if (cmd == "turbo") begin
					code = $fscanf(fd, "%h", f[0]);
					turbo_sequence(f[0]);
				end else begin
					$display("Unknown command in the input file");
					errors++;
					done = 1;
				end
			end
			$fclose(fd);
		end
		check_led();
		$display("value errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: tests/tb_mac_glue_input.txt
# one scenario per line, numbers in hex: mem field | dl idx word b0 b1 b2 b3 ins dbl
# ej mask ins dbl | cpu addr ctl(uds,lds,rom_oe,ram_oe,ram_we) data sdout ack exp_data scr | turbo acks
mem 2
mem 1
cpu 0f8000 06 cafe 1234 0 1234 1
cpu 0f0000 06 0bad beef 0 beef 0
cpu 000101 05 0000 a55a 1 5a5a 0
cpu 000100 05 0000 a55a 2 a5a5 0
cpu 3ffffe 03 0000 4e71 0 4e71 0
dl 0 0 4e 71 60 fe 0 0
dl 0 2 12 34 ab cd 0 0
dl 1 63ffe 00 ff 5a a5 1 1
dl 2 31ffe c3 3c 80 01 3 1
ej 1 2 0
ej 2 0 0
mem 3
cpu 018000 06 1111 0000 0 0000 1
cpu 010000 06 2222 7f80 0 7f80 0
cpu 01c001 05 0000 1ee7 1 e7e7 0
turbo 3
